/* rtl/cpuPkg.sv */
package cpuPkg;

	// --------------------------------------------------
	// widths with a meaning
	// --------------------------------------------------
	typedef logic [15:0] word_t;
	typedef logic [2:0]  regIdx_t;
	typedef logic [4:0]  opcode_t;
	typedef logic [1:0]  aluSel_t;
	typedef logic [1:0]  fwdSel_t;

	// --------------------------------------------------
	// opcodes, instruction bits 15..11
	// --------------------------------------------------
	localparam opcode_t OP_NOP   = 5'b00001;
	localparam opcode_t OP_ADDIU = 5'b01001;
	localparam opcode_t OP_LI    = 5'b01101;
	localparam opcode_t OP_RRR   = 5'b11100;
	localparam opcode_t OP_LW    = 5'b10011;
	localparam opcode_t OP_SW    = 5'b11011;
	localparam opcode_t OP_BEQZ  = 5'b00100;
	localparam opcode_t OP_JR    = 5'b11101;

	// function field of OP_RRR, bits 1..0
	localparam logic [1:0] FN_ADDU = 2'b01;
	localparam logic [1:0] FN_SUBU = 2'b11;

	// lowest bit of each instruction field
	localparam int OP_LSB = 11;
	localparam int RX_LSB = 8;
	localparam int RY_LSB = 5;
	localparam int RZ_LSB = 2;

	// bubble word, opcode NOP with all other bits clear
	localparam word_t NOP_WORD = {OP_NOP, 11'b0};

	// alu functions
	localparam aluSel_t ALU_ADD   = 2'b00;
	localparam aluSel_t ALU_SUB   = 2'b01;
	localparam aluSel_t ALU_PASSB = 2'b10;

	// operand sources in execute
	localparam fwdSel_t FWD_REG   = 2'b00;
	localparam fwdSel_t FWD_EXMEM = 2'b01;
	localparam fwdSel_t FWD_MEMWB = 2'b10;

endpackage

/* rtl/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage import cpuPkg::*;
#(
	parameter word_t RESET_PC = 16'h0000
)
(
	input  logic  CLK,
	input  logic  RST,
	output word_t imemAddr,
	input  word_t imemData,
	input  logic  pcHold,
	input  logic  ifHold,
	input  logic  squash,
	input  logic  redirect,
	input  word_t redirectPc,
	output word_t ifPc,
	output word_t ifInstr
);

	word_t pc;
	word_t pcNext;

	assign imemAddr = pc;

	// a held PC keeps the redirect pending until the stall clears
	always_comb
	begin
		if (pcHold)
			pcNext = pc;
		else if (redirect)
			pcNext = redirectPc;
		else
			pcNext = pc + 16'd1;
	end

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			pc <= RESET_PC;
		else
			pc <= pcNext;
	end

	// --------------------------------------------------
	// IF/ID register
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			ifInstr <= NOP_WORD;
		else if (!ifHold)
			ifInstr <= squash ? NOP_WORD : imemData;
	end

	always_ff @(posedge CLK)
	begin
		if (!ifHold)
			ifPc <= pc;
	end

endmodule

/* rtl/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import cpuPkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  word_t   ifPc,
	input  word_t   ifInstr,
	input  word_t   rdA,
	input  word_t   rdB,
	input  logic    idBubble,
	input  logic    freeze,
	output regIdx_t srcA,
	output regIdx_t srcB,
	output word_t   exPc,
	output word_t   exOpA,
	output word_t   exOpB,
	output word_t   exImm,
	output regIdx_t exSrcA,
	output regIdx_t exSrcB,
	output regIdx_t exDst,
	output aluSel_t exAlu,
	output logic    exUseImm,
	output logic    exRegWr,
	output logic    exLoad,
	output logic    exStore,
	output logic    exBranch,
	output logic    exJump
);

	opcode_t    op;
	regIdx_t    rx;
	regIdx_t    ry;
	regIdx_t    rz;
	logic [1:0] fn;
	word_t      immS8;
	word_t      immZ8;
	word_t      immS5;
	word_t      imm;
	regIdx_t    dst;
	aluSel_t    alu;
	logic       useImm;
	logic       regWr;
	logic       load;
	logic       store;
	logic       branch;
	logic       jump;

	assign op = ifInstr[OP_LSB +: 5];
	assign rx = ifInstr[RX_LSB +: 3];
	assign ry = ifInstr[RY_LSB +: 3];
	assign rz = ifInstr[RZ_LSB +: 3];
	assign fn = ifInstr[1:0];

	// rx and ry are always read, unused ones only cost a spare stall
	assign srcA = rx;
	assign srcB = ry;

	assign immS8 = {{8{ifInstr[7]}}, ifInstr[7:0]};
	assign immZ8 = {8'b0, ifInstr[7:0]};
	assign immS5 = {{11{ifInstr[4]}}, ifInstr[4:0]};

	// --------------------------------------------------
	// control decode
	// --------------------------------------------------
	always_comb
	begin
		imm    = immS8;
		dst    = rx;
		alu    = ALU_ADD;
		useImm = 1'b0;
		regWr  = 1'b0;
		load   = 1'b0;
		store  = 1'b0;
		branch = 1'b0;
		jump   = 1'b0;
		case (op)
			OP_ADDIU:
			begin
				useImm = 1'b1;
				regWr  = 1'b1;
			end
			OP_LI:
			begin
				imm    = immZ8;
				alu    = ALU_PASSB;
				useImm = 1'b1;
				regWr  = 1'b1;
			end
			OP_RRR:
			begin
				dst   = rz;
				alu   = (fn == FN_SUBU) ? ALU_SUB : ALU_ADD;
				regWr = (fn == FN_ADDU) || (fn == FN_SUBU);
			end
			OP_LW:
			begin
				imm    = immS5;
				dst    = ry;
				useImm = 1'b1;
				regWr  = 1'b1;
				load   = 1'b1;
			end
			OP_SW:
			begin
				imm    = immS5;
				useImm = 1'b1;
				store  = 1'b1;
			end
			OP_BEQZ:
				branch = 1'b1;
			OP_JR:
				jump = (ifInstr[7:0] == 8'h00);
			default:
				;
		endcase
	end

	// --------------------------------------------------
	// ID/EX register
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			exRegWr  <= 1'b0;
			exLoad   <= 1'b0;
			exStore  <= 1'b0;
			exBranch <= 1'b0;
			exJump   <= 1'b0;
		end
		else if (!freeze)
		begin
			exRegWr  <= regWr && !idBubble;
			exLoad   <= load && !idBubble;
			exStore  <= store && !idBubble;
			exBranch <= branch && !idBubble;
			exJump   <= jump && !idBubble;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!freeze)
		begin
			exPc     <= ifPc;
			exOpA    <= rdA;
			exOpB    <= rdB;
			exImm    <= imm;
			exSrcA   <= rx;
			exSrcB   <= ry;
			exDst    <= dst;
			exAlu    <= alu;
			exUseImm <= useImm;
		end
	end

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile import cpuPkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  regIdx_t srcA,
	input  regIdx_t srcB,
	output word_t   rdA,
	output word_t   rdB,
	input  logic    wbEn,
	input  regIdx_t wbReg,
	input  word_t   wbData
);

	word_t regs [0:7];

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else if (wbEn)
			regs[wbReg] <= wbData;
	end

	// write-through, decode sees the value being written this cycle
	assign rdA = (wbEn && wbReg == srcA) ? wbData : regs[srcA];
	assign rdB = (wbEn && wbReg == srcB) ? wbData : regs[srcB];

endmodule

/* rtl/executeStage.sv */
`timescale 1ns/1ps

module executeStage import cpuPkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  logic    freeze,
	input  word_t   exPc,
	input  word_t   exOpA,
	input  word_t   exOpB,
	input  word_t   exImm,
	input  regIdx_t exDst,
	input  aluSel_t exAlu,
	input  logic    exUseImm,
	input  logic    exRegWr,
	input  logic    exLoad,
	input  logic    exStore,
	input  logic    exBranch,
	input  logic    exJump,
	input  fwdSel_t fwdA,
	input  fwdSel_t fwdB,
	input  word_t   wbData,
	output logic    redirect,
	output word_t   redirectPc,
	output word_t   memAddr,
	output word_t   memData,
	output logic    memLoad,
	output logic    memStore,
	output logic    memRegWr,
	output regIdx_t memDst,
	output word_t   memResult
);

	word_t memAlu;
	word_t fwdValA;
	word_t fwdValB;
	word_t heldA;
	word_t heldB;
	logic  heldValid;
	word_t opA;
	word_t opB;
	word_t aluB;
	word_t aluOut;

	function automatic word_t pickOperand(fwdSel_t sel, word_t regVal);
		case (sel)
			FWD_EXMEM: return memAlu;
			FWD_MEMWB: return wbData;
			default:   return regVal;
		endcase
	endfunction

	always_comb
	begin
		fwdValA = pickOperand(fwdA, exOpA);
		fwdValB = pickOperand(fwdB, exOpB);
	end

	// MEM/WB empties during a data wait, so the operands seen on
	// the first wait cycle are kept until the stage moves on
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			heldValid <= 1'b0;
		else
			heldValid <= freeze;
	end

	always_ff @(posedge CLK)
	begin
		if (freeze && !heldValid)
		begin
			heldA <= fwdValA;
			heldB <= fwdValB;
		end
	end

	assign opA = heldValid ? heldA : fwdValA;
	assign opB = heldValid ? heldB : fwdValB;

	// --------------------------------------------------
	// alu and control transfer
	// --------------------------------------------------
	assign aluB = exUseImm ? exImm : opB;

	always_comb
	begin
		case (exAlu)
			ALU_ADD: aluOut = opA + aluB;
			ALU_SUB: aluOut = opA - aluB;
			default: aluOut = aluB;
		endcase
	end

	// delay slot is already in decode and proceeds
	assign redirect   = exJump || (exBranch && opA == '0);
	assign redirectPc = exJump ? opA : exPc + 16'd1 + exImm;

	// --------------------------------------------------
	// EX/MEM register
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			memLoad  <= 1'b0;
			memStore <= 1'b0;
			memRegWr <= 1'b0;
		end
		else if (!freeze)
		begin
			memLoad  <= exLoad;
			memStore <= exStore;
			memRegWr <= exRegWr;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!freeze)
		begin
			memAlu  <= aluOut;
			memData <= opB;
			memDst  <= exDst;
		end
	end

	// alu result doubles as the data address
	assign memAddr   = memAlu;
	assign memResult = memAlu;

endmodule

/* rtl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import cpuPkg::*;
(
	input  regIdx_t srcA,
	input  regIdx_t srcB,
	input  regIdx_t exSrcA,
	input  regIdx_t exSrcB,
	input  regIdx_t exDst,
	input  logic    exLoad,
	input  logic    exRegWr,
	input  regIdx_t memDst,
	input  logic    memRegWr,
	input  regIdx_t wbReg,
	input  logic    wbEn,
	input  logic    memWait,
	input  logic    redirect,
	output logic    pcHold,
	output logic    ifHold,
	output logic    idBubble,
	output logic    freeze,
	output logic    squash,
	output fwdSel_t fwdA,
	output fwdSel_t fwdB
);

	logic loadUse;

	// newest producer wins, register 0 included
	function automatic fwdSel_t pickSource(regIdx_t src);
		if (memRegWr && memDst == src)
			return FWD_EXMEM;
		else if (wbEn && wbReg == src)
			return FWD_MEMWB;
		else
			return FWD_REG;
	endfunction

	always_comb
	begin
		fwdA = pickSource(exSrcA);
		fwdB = pickSource(exSrcB);
	end

	// load data only exists after MEM, one bubble covers the gap
	assign loadUse = exLoad && exRegWr && (exDst == srcA || exDst == srcB);

	// --------------------------------------------------
	// stage enables
	// --------------------------------------------------
	assign freeze   = memWait;
	assign pcHold   = memWait || loadUse;
	assign ifHold   = memWait || loadUse;
	assign idBubble = loadUse && !memWait;
	assign squash   = redirect && !memWait;

endmodule

/* rtl/memAccess.sv */
`timescale 1ns/1ps

module memAccess import cpuPkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  word_t   memAddr,
	input  word_t   memData,
	input  logic    memLoad,
	input  logic    memStore,
	input  logic    memRegWr,
	input  regIdx_t memDst,
	input  word_t   memResult,
	output word_t   wbAdr,
	output word_t   wbDatO,
	input  word_t   wbDatI,
	output logic    wbWe,
	output logic    wbCyc,
	output logic    wbStb,
	input  logic    wbAck,
	output logic    memWait,
	output logic    wbEn,
	output regIdx_t wbReg,
	output word_t   wbData
);

	logic  access;
	word_t wbSel;

	// --------------------------------------------------
	// wishbone classic master
	// --------------------------------------------------
	// EX/MEM only moves on ACK, so the cycle ends with it
	assign access  = memLoad || memStore;
	assign wbCyc   = access;
	assign wbStb   = access;
	assign wbWe    = memStore;
	assign wbAdr   = memAddr;
	assign wbDatO  = memData;
	assign memWait = wbStb && !wbAck;

	// load data or alu result
	assign wbSel = memLoad ? wbDatI : memResult;

	// --------------------------------------------------
	// MEM/WB register
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			wbEn <= 1'b0;
		else
			wbEn <= memRegWr && !memWait;
	end

	always_ff @(posedge CLK)
	begin
		if (!memWait)
		begin
			wbReg  <= memDst;
			wbData <= wbSel;
		end
	end

endmodule

/* rtl/pipelineCpu.sv */
`timescale 1ns/1ps

module pipelineCpu import cpuPkg::*;
#(
	parameter word_t RESET_PC = 16'h0000
)
(
	input  logic  CLK,
	input  logic  RST,
	output word_t imemAddr,
	input  word_t imemData,
	output word_t wbAdr,
	output word_t wbDatO,
	input  word_t wbDatI,
	output logic  wbWe,
	output logic  wbCyc,
	output logic  wbStb,
	input  logic  wbAck
);

	// --------------------------------------------------
	// stage enables
	// --------------------------------------------------
	logic    pcHold;
	logic    ifHold;
	logic    idBubble;
	logic    freeze;
	logic    squash;
	logic    memWait;
	fwdSel_t fwdA;
	fwdSel_t fwdB;

	// IF/ID and register file
	word_t   ifPc;
	word_t   ifInstr;
	regIdx_t srcA;
	regIdx_t srcB;
	word_t   rdA;
	word_t   rdB;

	// ID/EX
	word_t   exPc;
	word_t   exOpA;
	word_t   exOpB;
	word_t   exImm;
	regIdx_t exSrcA;
	regIdx_t exSrcB;
	regIdx_t exDst;
	aluSel_t exAlu;
	logic    exUseImm;
	logic    exRegWr;
	logic    exLoad;
	logic    exStore;
	logic    exBranch;
	logic    exJump;

	// branch and jump resolution
	logic    redirect;
	word_t   redirectPc;

	// EX/MEM
	word_t   memAddr;
	word_t   memData;
	word_t   memResult;
	regIdx_t memDst;
	logic    memLoad;
	logic    memStore;
	logic    memRegWr;

	// write-back bus
	logic    wbEn;
	regIdx_t wbReg;
	word_t   wbData;

	// --------------------------------------------------
	// stages
	// --------------------------------------------------
	fetchStage #(.RESET_PC(RESET_PC)) fetch (.*);

	decodeStage decode (.*);

	regFile regs (.*);

	executeStage execute (.*);

	hazardUnit hazard (.*);

	memAccess mem (.*);

endmodule

/* verif/cpuChk.sv */
`timescale 1ns/1ps

module cpuChk import cpuPkg::*;
(
	input logic  CLK,
	input logic  RST,
	input logic  wbCyc,
	input logic  wbStb,
	input logic  wbWe,
	input logic  wbAck,
	input word_t wbAdr,
	input word_t wbDatO
);

	// --------------------------------------------------
	// wishbone classic master rules
	// --------------------------------------------------
	// a waiting strobe stays inside its cycle until the slave answers
	stbInCyc: assert property (@(posedge CLK) disable iff (!RST)
		(wbStb && !wbAck) |=> (wbStb && wbCyc))
		else $error("STB or CYC dropped before ACK");

	// request held until the slave answers
	holdRequest: assert property (@(posedge CLK) disable iff (!RST)
		(wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbDatO) && $stable(wbWe)))
		else $error("address, data or WE changed while STB waited for ACK");

	idleInReset: assert property (@(posedge CLK) !RST |-> !wbCyc)
		else $error("CYC high during reset");

endmodule

bind memAccess cpuChk chk
(
	.CLK(CLK),
	.RST(RST),
	.wbCyc(wbCyc),
	.wbStb(wbStb),
	.wbWe(wbWe),
	.wbAck(wbAck),
	.wbAdr(wbAdr),
	.wbDatO(wbDatO)
);

/* verif/tbPipelineCpu.sv */
`timescale 1ns/1ps

module tbPipelineCpu import cpuPkg::*;
();

	localparam int          PERIOD        = 40;
	localparam int          RESET_CYCLES  = 16;
	localparam int          STORE_TIMEOUT = 200;
	localparam int          LOOP_TIMEOUT  = 200;
	localparam int          SETTLE_CYCLES = 8;
	localparam logic [31:0] SEED          = 32'd97347;
	localparam word_t       RESET_ADDR    = 16'h0000;
	localparam logic [4:0]  BEQZ_OP       = 5'b00100;

	logic  CLK    = 1'b0;
	logic  RST    = 1'b0;
	word_t imemAddr;
	word_t imemData;
	word_t wbAdr;
	word_t wbDatO;
	word_t wbDatI = 16'h0000;
	logic  wbWe;
	logic  wbCyc;
	logic  wbStb;
	logic  wbAck  = 1'b0;

	word_t       imem [0:255];
	word_t       dmem [0:255];
	word_t       expAdr [$];
	word_t       expDat [$];
	word_t       loopAddr;
	int          storeCount = 0;
	int          expCount   = 0;
	int          caseCount  = 0;
	int          fd;
	bit          found;
	logic [31:0] rngState   = SEED;
	logic        busy       = 1'b0;
	int          waitLeft   = 0;

	always #(PERIOD / 2) CLK = ~CLK;

	pipelineCpu #(.RESET_PC(RESET_ADDR)) uut
	(
		.CLK(CLK),
		.RST(RST),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.wbAdr(wbAdr),
		.wbDatO(wbDatO),
		.wbDatI(wbDatI),
		.wbWe(wbWe),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbAck(wbAck)
	);

	// --------------------------------------------------
	// reporting and compares
	// --------------------------------------------------
	task automatic reportError(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkWord(input string name, input word_t got, input word_t expected);
		if (got !== expected)
			reportError($sformatf("ERROR %s got %h expected %h", name, got, expected));
	endtask

	task automatic checkCount(input string what, input int got, input int expected);
		if (got != expected)
			reportError($sformatf("case %0d saw %0d %s where %0d were expected",
				caseCount + 1, got, what, expected));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// --------------------------------------------------
	// memory models
	// --------------------------------------------------
	// instruction memory answers within the cycle
	assign imemData = imem[imemAddr[7:0]];

	task automatic recordStore(input word_t adr, input word_t dat);
		word_t nextAdr;
		word_t nextDat;
		if (expAdr.size() == 0)
		begin
			// one store beyond the expected list
			storeCount++;
			checkCount("stores", storeCount, expCount);
		end
		else
		begin
			nextAdr = expAdr.pop_front();
			nextDat = expDat.pop_front();
			checkWord("wbAdr", adr, nextAdr);
			checkWord("wbDatO", dat, nextDat);
			storeCount++;
		end
	endtask

	// data slave, 0 to 3 wait cycles before each ACK
	always @(posedge CLK)
	begin
		if (!RST)
		begin
			wbAck <= 1'b0;
			busy = 1'b0;
		end
		else if (wbStb && wbAck)
		begin
			wbAck <= 1'b0;
			busy = 1'b0;
			if (wbWe)
			begin
				dmem[wbAdr[7:0]] = wbDatO;
				recordStore(wbAdr, wbDatO);
			end
		end
		else if (wbStb)
		begin
			if (!busy)
			begin
				busy = 1'b1;
				rngState = xorshift(rngState);
				waitLeft = int'(rngState[1:0]);
			end
			if (waitLeft == 0)
			begin
				wbAck <= 1'b1;
				wbDatI <= dmem[wbAdr[7:0]];
			end
			else
				waitLeft--;
		end
	end

	// --------------------------------------------------
	// case loading and reset
	// --------------------------------------------------
	// unused words decode as NOP, data words carry their own address
	task automatic fillMemories();
		for (int i = 0; i < 256; i++)
		begin
			imem[8'(i)] = {5'b00001, 3'b000, 8'(i)};
			dmem[8'(i)] = {~8'(i), 8'(i)};
		end
		expAdr.delete();
		expDat.delete();
		storeCount = 0;
		expCount = 0;
		loopAddr = 16'hFFFF;
	endtask

	task automatic loadCase(output bit gotCase);
		logic [7:0]       tag;
		logic [8*128-1:0] rest;
		word_t            addr;
		word_t            value;
		int               code;
		bit               done;
		gotCase = 1'b0;
		done = 1'b0;
		while (!done)
		begin
			code = $fscanf(fd, "%s", tag);
			if (code != 1)
				done = 1'b1;
			else if (tag == "#")
				code = $fgets(rest, fd);
			else if (tag == "E")
			begin
				gotCase = 1'b1;
				done = 1'b1;
			end
			else
			begin
				code = $fscanf(fd, " %h %h", addr, value);
				if (code != 2)
					reportError("malformed line in verif/cpuCases.txt");
				else if (tag == "P")
				begin
					imem[addr[7:0]] = value;
					// BEQZ with offset -1 branches to itself
					if (value[15:11] == BEQZ_OP && value[7:0] == 8'hFF)
						loopAddr = addr;
				end
				else if (tag == "M")
					dmem[addr[7:0]] = value;
				else if (tag == "W")
				begin
					expAdr.push_back(addr);
					expDat.push_back(value);
					expCount++;
				end
				else
					reportError("unknown tag in verif/cpuCases.txt");
			end
		end
	endtask

	task automatic startReset();
		@(posedge CLK);
		RST <= 1'b0;
		@(posedge CLK);
	endtask

	task automatic finishReset();
		for (int i = 0; i < RESET_CYCLES - 1; i++)
		begin
			@(posedge CLK);
			if (wbCyc !== 1'b0)
				reportError("a Wishbone cycle started while reset was asserted");
		end
		RST <= 1'b1;
		@(posedge CLK);
		checkWord("imemAddr", imemAddr, RESET_ADDR);
	endtask

	// --------------------------------------------------
	// waits
	// --------------------------------------------------
	task automatic waitForStores();
		int cycles;
		int pending;
		cycles = 0;
		pending = expAdr.size();
		while (expAdr.size() != 0)
		begin
			if (cycles >= STORE_TIMEOUT)
				reportError($sformatf("case %0d timed out waiting for store %0d of %0d",
					caseCount + 1, expCount - expAdr.size() + 1, expCount));
			else
			begin
				@(posedge CLK);
				cycles++;
				if (expAdr.size() != pending)
				begin
					pending = expAdr.size();
					cycles = 0;
				end
			end
		end
	endtask

	// the loop is reached once its target has been fetched again
	task automatic waitForLoop();
		int    cycles;
		int    entries;
		word_t prevAddr;
		cycles = 0;
		entries = 0;
		prevAddr = ~loopAddr;
		while (entries < 2)
		begin
			if (cycles >= LOOP_TIMEOUT)
				reportError($sformatf("case %0d never reached its closing self-loop",
					caseCount + 1));
			else
			begin
				@(posedge CLK);
				cycles++;
				if (imemAddr == loopAddr && prevAddr != loopAddr)
					entries++;
				prevAddr = imemAddr;
			end
		end
	endtask

	task automatic runCase();
		waitForStores();
		waitForLoop();
		repeat (SETTLE_CYCLES) @(posedge CLK);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial
	begin
		fd = $fopen("verif/cpuCases.txt", "r");
		if (fd == 0)
			reportError("could not open verif/cpuCases.txt");
		else
		begin
			found = 1'b1;
			while (found)
			begin
				startReset();
				fillMemories();
				loadCase(found);
				if (found)
				begin
					finishReset();
					runCase();
					caseCount++;
				end
			end
			$fclose(fd);
			if (caseCount == 0)
				reportError("verif/cpuCases.txt holds no complete case");
			else
			begin
				$display("=== PASS ===");
				$finish;
			end
		end
	end

endmodule

/* verif/cpuCases.txt */
# P address word: instruction memory   M address word: initial data memory
# W address data: next expected store, in order   E: end of a case
# case 1: alu and immediate chains through every forwarding path
P 0000 6905
P 0001 4903
P 0002 E129
P 0003 E22F
P 0004 6C40
P 0005 DC60
P 0006 DC41
P 0007 4BFF
P 0008 6811
P 0009 E037
P 000A DC62
P 000B DCA3
P 000C 27FF
P 000D 0800
W 0040 0008
W 0041 0010
W 0042 0007
W 0043 0009
E
# case 2: loads used by the next instruction
M 0030 1234
P 0000 6930
P 0001 9940
P 0002 4A05
P 0003 D941
P 0004 9961
P 0005 E353
P 0006 D982
P 0007 99BF
P 0008 4D01
P 0009 D9A3
P 000A 27FF
P 000B 0800
W 0031 1239
W 0032 0000
W 0033 D030
E
# case 3: BEQZ not taken, taken on r0, taken on a forwarded zero
P 0000 6950
P 0001 6A01
P 0002 2203
P 0003 D940
P 0004 D941
P 0005 2003
P 0006 D922
P 0007 D943
P 0008 D944
P 0009 6B77
P 000A D965
P 000B E373
P 000C 2402
P 000D 4B01
P 000E 6BEE
P 000F D966
P 0010 27FF
P 0011 0800
W 0050 0001
W 0051 0001
W 0052 0050
W 0055 0077
W 0056 0078
E
# case 4: JR to computed targets with stores in the delay slot
P 0000 690A
P 0001 6A60
P 0002 4902
P 0003 E900
P 0004 DA20
P 0005 DA41
P 000C 6B3C
P 000D DA62
P 000E EB00
P 000F 4B10
P 0010 DA64
P 003C DA63
P 003D 27FF
P 003E 0800
W 0060 000C
W 0062 003C
W 0063 004C
E

/* list.f */
rtl/cpuPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/regFile.sv
rtl/executeStage.sv
rtl/hazardUnit.sv
rtl/memAccess.sv
rtl/pipelineCpu.sv
verif/cpuChk.sv
verif/tbPipelineCpu.sv

/* run.sh */
#!/bin/sh
# build and run the pipelined core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tbPipelineCpu -o simv \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1 || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
